/* logic/api_macros.svh */
`ifndef API_MACROS_SVH
`define API_MACROS_SVH

// number of chips sharing the serial link.
`define API_NUM 10

// reply words kept from each job.
`define API_RX_BLOCK_LEN 11

// words in one full job.
`define API_WORK_LEN 23

// fifo depths in words, powers of two.
`define API_TX_DEPTH 64
`define API_RX_DEPTH 64

// reply word that flags a found nonce.
`define API_NONCE_MARK 32'hbeafbeaf

`endif

/* logic/api_cfg_pkg.sv */
`default_nettype none

package api_cfg_pkg;

	// minimum spacing between job starts, in clocks.
	typedef logic [27:0] timeout_t;

	// serial half-period minus one, in clocks.
	typedef logic [7:0] sck_div_t;

	// words sent per job.
	typedef logic [7:0] word_num_t;

endpackage

`default_nettype wire

/* logic/api_link_pkg.sv */
`default_nettype none

package api_link_pkg;

	// one word on the link or in a fifo.
	typedef logic [31:0] link_word_t;

	// chip index, all chips deselected reads as 10.
	typedef logic [3:0] miner_id_t;

	// position of a reply within a job.
	typedef logic [4:0] word_idx_t;

	// fifo fill level, holds 0 up to the full depth.
	typedef logic [6:0] fifo_count_t;

	typedef enum logic [1:0] {
		st_wait,
		st_work,
		st_nop
	} ctrl_state_t;

endpackage

`default_nettype wire

/* logic/api_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module api_timer (
	input  logic                  clk,
	input  logic                  rst,
	input  api_cfg_pkg::timeout_t reg_timeout,
	input  logic                  start,
	output logic                  busy
);
	import api_cfg_pkg::*;

	timeout_t cnt;

	// reloads on every job start.
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (start) begin
			cnt <= reg_timeout;
		end else if (cnt != '0) begin
			cnt <= cnt - timeout_t'(1);
		end
	end

	assign busy = (cnt != '0);

endmodule

`default_nettype wire

/* logic/api_phy.sv */
`timescale 1ns/1ps
`default_nettype none

module api_phy (
	input  logic                     clk,
	input  logic                     rst,
	input  api_cfg_pkg::sck_div_t    sck_div,
	input  logic                     mosi_vld,
	input  api_link_pkg::link_word_t mosi_dat,
	output logic                     miso_vld,
	output api_link_pkg::link_word_t miso_dat,
	output logic                     sck,
	output logic                     mosi,
	input  logic                     miso
);
	import api_cfg_pkg::*;
	import api_link_pkg::*;

	logic       active;
	logic       load_word;
	logic       half_end;
	sck_div_t   div_cnt;
	logic [5:0] bit_cnt;
	link_word_t tx_sr;

	assign load_word = mosi_vld && !active;
	assign half_end = active && (div_cnt == sck_div);

	// bit_cnt counts sck edges, 64 per word.
	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			sck <= 1'b0;
		end else if (load_word) begin
			active <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
			sck <= 1'b0;
		end else if (half_end) begin
			div_cnt <= '0;
			bit_cnt <= bit_cnt + 6'd1;
			sck <= ~sck;
			if (bit_cnt == 6'd63) begin
				active <= 1'b0;
			end
		end else if (active) begin
			div_cnt <= div_cnt + sck_div_t'(1);
		end
	end

	// sample miso as sck rises, move mosi on as it falls.
	always_ff @(posedge clk) begin
		if (load_word) begin
			tx_sr <= mosi_dat;
		end else if (half_end) begin
			if (!sck) begin
				miso_dat <= {miso_dat[30:0], miso};
			end else begin
				tx_sr <= {tx_sr[30:0], 1'b0};
			end
		end
	end

	assign mosi = tx_sr[31];

	// the last falling edge, the captured word is complete.
	assign miso_vld = half_end && (bit_cnt == 6'd63);

endmodule

`default_nettype wire

/* logic/api_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "api_macros.svh"

module api_fifo #(
	parameter int DEPTH = `API_TX_DEPTH
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wr_en,
	input  api_link_pkg::link_word_t  din,
	input  logic                      rd_en,
	output api_link_pkg::link_word_t  dout,
	output logic                      full,
	output logic                      empty,
	output api_link_pkg::fifo_count_t count
);
	import api_link_pkg::*;

	localparam int AW = $clog2(DEPTH);

	link_word_t      mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic            do_wr;
	logic            do_rd;

	// writes to a full fifo and reads of an empty one are dropped.
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + fifo_count_t'(do_wr) - fifo_count_t'(do_rd);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	assign dout = mem[rd_ptr];
	assign full = (count == fifo_count_t'(DEPTH));
	assign empty = (count == '0);

endmodule

`default_nettype wire

/* logic/api_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "api_macros.svh"

module api_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  api_cfg_pkg::word_num_t    reg_word_num,
	input  api_cfg_pkg::timeout_t     reg_timeout,
	input  api_cfg_pkg::sck_div_t     sck_div,
	input  logic                      tx_empty,
	output logic                      tx_rd_en,
	input  api_link_pkg::link_word_t  tx_dout,
	input  api_link_pkg::fifo_count_t rx_count,
	output api_link_pkg::ctrl_state_t state,
	output api_link_pkg::word_idx_t   word_idx,
	output api_link_pkg::miner_id_t   miner_id,
	output logic                      miso_vld,
	output api_link_pkg::link_word_t  miso_dat,
	output logic [`API_NUM-1:0]       load,
	output logic                      sck,
	output logic                      mosi,
	input  logic [`API_NUM-1:0]       miso
);
	import api_cfg_pkg::*;
	import api_link_pkg::*;

	ctrl_state_t state_nxt;
	word_num_t   word_cnt;
	logic [3:0]  nop_cnt;
	logic        mosi_vld;
	logic        timer_busy;
	logic        rx_room;
	logic        job_start;
	logic        miso_line;

	// a whole reply block must fit before a job may start.
	assign rx_room = (fifo_count_t'(`API_RX_DEPTH) - rx_count) >=
		fifo_count_t'(`API_RX_BLOCK_LEN);
	assign job_start = (state == st_wait) && !timer_busy && !tx_empty && rx_room;

	always_comb begin
		state_nxt = state;
		case (state)
			st_wait: begin
				if (job_start) begin
					state_nxt = st_work;
				end
			end
			st_work: begin
				if (word_cnt == reg_word_num) begin
					state_nxt = st_nop;
				end
			end
			st_nop: begin
				if (nop_cnt == 4'hf) begin
					state_nxt = st_wait;
				end
			end
			default: state_nxt = st_wait;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_wait;
		end else begin
			state <= state_nxt;
		end
	end

	// word_idx wraps per full job, word_cnt stops at the job length.
	always_ff @(posedge clk) begin
		if (rst) begin
			word_cnt <= '0;
			word_idx <= '0;
		end else if (job_start) begin
			word_cnt <= '0;
			word_idx <= '0;
		end else if (state == st_work && miso_vld && word_cnt != reg_word_num) begin
			word_cnt <= word_cnt + word_num_t'(1);
			if (word_idx == word_idx_t'(`API_WORK_LEN - 1)) begin
				word_idx <= '0;
			end else begin
				word_idx <= word_idx + word_idx_t'(1);
			end
		end
	end

	// one word in flight, the next goes out right after the reply.
	always_ff @(posedge clk) begin
		if (rst) begin
			mosi_vld <= 1'b0;
		end else begin
			mosi_vld <= job_start ||
				(state == st_work && miso_vld && word_cnt < reg_word_num - word_num_t'(1));
		end
	end

	assign tx_rd_en = mosi_vld;

	// idle gap of 15 cycles after each job.
	always_ff @(posedge clk) begin
		if (rst) begin
			nop_cnt <= '0;
		end else if (state != st_nop) begin
			nop_cnt <= 4'd1;
		end else begin
			nop_cnt <= nop_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			load <= {{(`API_NUM - 1){1'b1}}, 1'b0};
		end else if (state == st_nop && state_nxt == st_wait) begin
			load <= {load[`API_NUM-2:0], load[`API_NUM-1]};
		end
	end

	always_comb begin
		miner_id = miner_id_t'(`API_NUM);
		for (int i = 0; i < `API_NUM; i++) begin
			if (load == ~(`API_NUM'(1) << i)) begin
				miner_id = miner_id_t'(i);
			end
		end
	end

	// deselected chips are forced high before the wired-and.
	assign miso_line = &(miso | load);

	api_timer api_timer_i (
		.clk         (clk),
		.rst         (rst),
		.reg_timeout (reg_timeout),
		.start       (job_start),
		.busy        (timer_busy)
	);

	api_phy api_phy_i (
		.clk      (clk),
		.rst      (rst),
		.sck_div  (sck_div),
		.mosi_vld (mosi_vld),
		.mosi_dat (tx_dout),
		.miso_vld (miso_vld),
		.miso_dat (miso_dat),
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso_line)
	);

endmodule

`default_nettype wire

/* logic/api_rx_tag.sv */
`timescale 1ns/1ps
`default_nettype none
`include "api_macros.svh"

module api_rx_tag (
	input  logic                      clk,
	input  logic                      rst,
	input  api_link_pkg::ctrl_state_t state,
	input  api_link_pkg::word_idx_t   word_idx,
	input  api_link_pkg::miner_id_t   miner_id,
	input  logic                      miso_vld,
	input  api_link_pkg::link_word_t  miso_dat,
	output logic                      rx_wr_en,
	output api_link_pkg::link_word_t  rx_din,
	output logic                      led_nonce_l,
	output logic                      led_nonce_h
);
	import api_link_pkg::*;

	logic arm_l;
	logic arm_h;
	logic bank_h;
	logic word9;
	logic nonce_hit;

	assign rx_wr_en = miso_vld && (state == st_work) &&
		(word_idx < word_idx_t'(`API_RX_BLOCK_LEN));

	// last word of the block carries the chip tag in its low half.
	assign rx_din = (word_idx == word_idx_t'(`API_RX_BLOCK_LEN - 1)) ?
		{miso_dat[31:16], 8'h12, 4'h0, miner_id} : miso_dat;

	assign bank_h = (miner_id >= miner_id_t'(`API_NUM / 2));
	assign word9 = rx_wr_en && (word_idx == word_idx_t'(`API_RX_BLOCK_LEN - 2));
	assign nonce_hit = word9 && (miso_dat == `API_NONCE_MARK);

	always_ff @(posedge clk) begin
		if (rst) begin
			arm_l <= 1'b0;
			arm_h <= 1'b0;
			led_nonce_l <= 1'b0;
			led_nonce_h <= 1'b0;
		end else begin
			led_nonce_l <= nonce_hit && arm_l;
			led_nonce_h <= nonce_hit && arm_h;
			if (rx_wr_en && word_idx == word_idx_t'(2)) begin
				arm_l <= !bank_h;
				arm_h <= bank_h;
			end else if (word9) begin
				arm_l <= 1'b0;
				arm_h <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/api_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "api_macros.svh"

module api_top (
	input  logic                      clk,
	input  logic                      rst,
	input  api_cfg_pkg::timeout_t     reg_timeout,
	input  api_cfg_pkg::sck_div_t     reg_sck,
	input  api_cfg_pkg::word_num_t    reg_word_num,
	input  logic                      tx_wr_en,
	input  api_link_pkg::link_word_t  tx_din,
	output logic                      tx_full,
	input  logic                      rx_rd_en,
	output api_link_pkg::link_word_t  rx_dout,
	output logic                      rx_empty,
	output api_link_pkg::ctrl_state_t reg_state,
	output logic [`API_NUM-1:0]       load,
	output logic                      sck,
	output logic                      mosi,
	input  logic [`API_NUM-1:0]       miso,
	output logic                      led_nonce_l,
	output logic                      led_nonce_h
);
	import api_link_pkg::*;

	logic        tx_rd_en;
	logic        tx_empty;
	link_word_t  tx_dout;
	logic        rx_wr_en;
	link_word_t  rx_din;
	fifo_count_t rx_count;
	word_idx_t   word_idx;
	miner_id_t   miner_id;
	logic        miso_vld;
	link_word_t  miso_dat;

	api_fifo #(
		.DEPTH (`API_TX_DEPTH)
	) tx_fifo_i (
		.clk   (clk),
		.rst   (rst),
		.wr_en (tx_wr_en),
		.din   (tx_din),
		.rd_en (tx_rd_en),
		.dout  (tx_dout),
		.full  (tx_full),
		.empty (tx_empty),
		.count ()
	);

	api_ctrl api_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.reg_word_num (reg_word_num),
		.reg_timeout  (reg_timeout),
		.sck_div      (reg_sck),
		.tx_empty     (tx_empty),
		.tx_rd_en     (tx_rd_en),
		.tx_dout      (tx_dout),
		.rx_count     (rx_count),
		.state        (reg_state),
		.word_idx     (word_idx),
		.miner_id     (miner_id),
		.miso_vld     (miso_vld),
		.miso_dat     (miso_dat),
		.load         (load),
		.sck          (sck),
		.mosi         (mosi),
		.miso         (miso)
	);

	api_rx_tag api_rx_tag_i (
		.clk         (clk),
		.rst         (rst),
		.state       (reg_state),
		.word_idx    (word_idx),
		.miner_id    (miner_id),
		.miso_vld    (miso_vld),
		.miso_dat    (miso_dat),
		.rx_wr_en    (rx_wr_en),
		.rx_din      (rx_din),
		.led_nonce_l (led_nonce_l),
		.led_nonce_h (led_nonce_h)
	);

	// the controller only starts a job when a full block fits.
	api_fifo #(
		.DEPTH (`API_RX_DEPTH)
	) rx_fifo_i (
		.clk   (clk),
		.rst   (rst),
		.wr_en (rx_wr_en),
		.din   (rx_din),
		.rd_en (rx_rd_en),
		.dout  (rx_dout),
		.full  (),
		.empty (rx_empty),
		.count (rx_count)
	);

endmodule

`default_nettype wire

/* testbench/api_chip_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "api_macros.svh"

module api_chip_model (
	input  logic                     [`API_NUM-1:0] load,
	input  logic                     sck,
	input  logic                     mosi,
	output logic                     [`API_NUM-1:0] miso,
	output int                       rec_cnt,
	output api_link_pkg::link_word_t rec_words [512]
);
	import api_link_pkg::*;

	logic [3:0] chip;
	logic [4:0] word_k = '0;
	logic [4:0] bit_n = '0;
	int         count = 0;
	link_word_t reply;
	link_word_t shift_in = '0;

	assign rec_cnt = count;

	// chip whose load strobe is low.
	always_comb begin
		chip = 4'(`API_NUM);
		for (int i = 0; i < `API_NUM; i++) begin
			if (!load[i]) begin
				chip = 4'(i);
			end
		end
	end

	always_comb begin
		reply = {8'hA5, 4'h0, chip, 8'h00, 3'b000, word_k};
		if (word_k == 5'd9 && !chip[0]) begin
			reply = `API_NONCE_MARK;
		end
	end

	// unselected chips leave the shared line high.
	always_comb begin
		miso = '1;
		if (chip < 4'(`API_NUM)) begin
			miso[chip] = reply[5'd31 - bit_n];
		end
	end

	always @(posedge sck) begin
		shift_in <= {shift_in[30:0], mosi};
	end

	// a word ends on its 32nd falling edge of sck.
	always @(negedge sck) begin
		bit_n <= bit_n + 5'd1;
		if (bit_n == 5'd31) begin
			rec_words[count] <= shift_in;
			count <= count + 1;
			word_k <= (word_k == 5'(`API_WORK_LEN - 1)) ? 5'd0 : word_k + 5'd1;
		end
	end

endmodule

`default_nettype wire

/* testbench/api_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "api_macros.svh"

module api_tb;
	import api_cfg_pkg::*;
	import api_link_pkg::*;

	localparam int WAIT_MAX = 20000;

	logic                clk;
	logic                rst;
	timeout_t            reg_timeout;
	sck_div_t            reg_sck;
	word_num_t           reg_word_num;
	logic                tx_wr_en;
	link_word_t          tx_din;
	logic                tx_full;
	logic                rx_rd_en;
	link_word_t          rx_dout;
	logic                rx_empty;
	ctrl_state_t         reg_state;
	logic [`API_NUM-1:0] load;
	logic                sck;
	logic                mosi;
	logic [`API_NUM-1:0] miso;
	logic                led_nonce_l;
	logic                led_nonce_h;
	int                  rec_cnt;
	link_word_t          rec_words [512];

	logic [31:0] lfsr;
	link_word_t  sent [$];
	int          start_cycle [$];
	ctrl_state_t prev_state;
	int          cycle = 0;
	int          jobs_done = 0;
	int          pulses_l = 0;
	int          pulses_h = 0;
	int          blocks_read = 0;
	int          test_errors = 0;
	int          total_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	api_top api_top_i (.*);

	api_chip_model chips_i (
		.load      (load),
		.sck       (sck),
		.mosi      (mosi),
		.miso      (miso),
		.rec_cnt   (rec_cnt),
		.rec_words (rec_words)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// job starts and ends, LED pulses and the load strobe, seen before each edge.
	always @(posedge clk) begin
		cycle <= cycle + 1;
		prev_state <= reg_state;
		if (!rst) begin
			if (prev_state == st_wait && reg_state == st_work) begin
				start_cycle.push_back(cycle);
			end
			if (prev_state == st_nop && reg_state == st_wait) begin
				jobs_done <= jobs_done + 1;
			end
			if (led_nonce_l) begin
				pulses_l <= pulses_l + 1;
			end
			if (led_nonce_h) begin
				pulses_h <= pulses_h + 1;
			end
			assert ($countones(~load) == 1) else begin
				$display("load strobe does not select exactly one chip: %b", load);
				test_errors++;
			end
		end
	end

	// fibonacci lfsr, taps 32 22 2 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic link_word_t random_word();
		link_word_t w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr_bit()};
		end
		return w;
	endfunction

	function automatic logic [`API_NUM-1:0] load_for(int c);
		logic [`API_NUM-1:0] l;
		l = ~(`API_NUM'(1) << c);
		return l;
	endfunction

	// reply k of chip c as it lands in the receive FIFO.
	function automatic link_word_t expected_word(int c, int k);
		link_word_t w;
		w = {8'hA5, 4'h0, 4'(c), 8'h00, 3'b000, 5'(k)};
		if (k == 9 && c % 2 == 0) begin
			w = `API_NONCE_MARK;
		end
		if (k == 10) begin
			w[15:0] = {8'h12, 4'h0, 4'(c)};
		end
		return w;
	endfunction

	task automatic check_word(string name, link_word_t exp, link_word_t act);
		assert (act === exp) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_cond(string what, logic ok);
		assert (ok) else begin
			$display("%s", what);
			test_errors++;
		end
	endtask

	task automatic end_test(string name);
		if (test_errors == 0) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic abort_on_timeout(string what);
		$display("timeout while waiting for %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic push_word(link_word_t w);
		int t;
		t = 0;
		while (tx_full) begin
			@(negedge clk);
			t++;
			if (t > WAIT_MAX) begin
				abort_on_timeout("room in the transmit FIFO");
			end
		end
		tx_wr_en = 1'b1;
		tx_din = w;
		@(negedge clk);
		tx_wr_en = 1'b0;
	endtask

	task automatic push_job();
		link_word_t w;
		for (int i = 0; i < `API_WORK_LEN; i++) begin
			w = random_word();
			sent.push_back(w);
			push_word(w);
		end
	endtask

	task automatic read_word(output link_word_t w);
		int t;
		t = 0;
		while (rx_empty) begin
			@(negedge clk);
			t++;
			if (t > WAIT_MAX) begin
				abort_on_timeout("a word in the receive FIFO");
			end
		end
		w = rx_dout;
		rx_rd_en = 1'b1;
		@(negedge clk);
		rx_rd_en = 1'b0;
	endtask

	task automatic read_block(string name, int first = 0);
		link_word_t w;
		int c;
		c = blocks_read % `API_NUM;
		for (int k = first; k < `API_RX_BLOCK_LEN; k++) begin
			read_word(w);
			check_word($sformatf("%s chip %0d word %0d", name, c, k), expected_word(c, k), w);
		end
		blocks_read++;
	endtask

	task automatic wait_jobs(int n);
		int t;
		t = 0;
		while (jobs_done < n) begin
			@(negedge clk);
			t++;
			if (t > 10 * WAIT_MAX) begin
				abort_on_timeout("a job to finish");
			end
		end
	endtask

	// one job at a time, then the strobe must have moved on by one chip.
	task automatic run_job(string name);
		int c;
		int n;
		int l0;
		int h0;
		c = blocks_read % `API_NUM;
		n = jobs_done + 1;
		l0 = pulses_l;
		h0 = pulses_h;
		push_job();
		read_block(name);
		wait_jobs(n);
		check_cond($sformatf("%s left extra receive words", name), rx_empty);
		check_word({name, " load"}, 32'(load_for((c + 1) % `API_NUM)), 32'(load));
		check_word({name, " low LED pulses"}, l0 + ((c % 2 == 0 && c < 5) ? 1 : 0), pulses_l);
		check_word({name, " high LED pulses"}, h0 + ((c % 2 == 0 && c >= 5) ? 1 : 0), pulses_h);
	endtask

	initial begin
		int done0;
		int gap;
		link_word_t w;
		rst = 1'b1;
		reg_timeout = 28'd200;
		reg_sck = 8'd1;
		reg_word_num = 8'd23;
		tx_wr_en = 1'b0;
		tx_din = '0;
		rx_rd_en = 1'b0;
		lfsr = 32'h02ebfbea;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_word("reset load", 32'(load_for(0)), 32'(load));
		check_cond("reg_state is not st_wait after reset", reg_state == st_wait);
		check_cond("sck or a nonce LED is high after reset", !sck && !led_nonce_l && !led_nonce_h);
		check_cond("receive FIFO is not empty after reset", rx_empty);
		end_test("reset");

		run_job("single_job");
		check_word("single_job mosi count", 32'(`API_WORK_LEN), 32'(rec_cnt));
		for (int i = 0; i < `API_WORK_LEN; i++) begin
			check_word($sformatf("single_job mosi word %0d", i), sent[i], rec_words[i]);
		end
		end_test("single_job");

		for (int j = 1; j < 12; j++) begin
			run_job($sformatf("rotation job %0d", j));
		end
		end_test("rotation");

		// chips 0 2 4 0 hit the low bank, 6 and 8 the high bank.
		check_word("nonce_leds low total", 4, pulses_l);
		check_word("nonce_leds high total", 2, pulses_h);
		end_test("nonce_leds");

		reg_timeout = 28'd5000;
		done0 = start_cycle.size();
		push_job();
		push_job();
		read_block("job_spacing");
		read_block("job_spacing");
		wait_jobs(jobs_done + 1);
		gap = start_cycle[done0 + 1] - start_cycle[done0];
		check_cond($sformatf("second job started only %0d clocks after the first", gap),
			gap >= 5000);
		reg_timeout = 28'd200;
		end_test("job_spacing");

		done0 = jobs_done;
		for (int j = 0; j < 6; j++) begin
			push_job();
		end
		// the last push had to wait for room, so the FIFO is full again.
		check_cond("transmit FIFO is not full with 138 words queued", tx_full);
		tx_wr_en = 1'b1;
		tx_din = 32'h5a5a5a5a;
		@(negedge clk);
		tx_wr_en = 1'b0;
		check_cond("transmit FIFO is no longer full after a write while full", tx_full);
		wait_jobs(done0 + 5);
		// one word read leaves ten free slots, still less than one block.
		read_word(w);
		check_word($sformatf("rx_backpressure chip %0d word 0", blocks_read % `API_NUM),
			expected_word(blocks_read % `API_NUM, 0), w);
		for (int i = 0; i < 300; i++) begin
			@(negedge clk);
			check_cond("controller left st_wait with too little receive room",
				reg_state == st_wait);
		end
		read_block("rx_backpressure", 1);
		for (int b = 1; b < 6; b++) begin
			read_block("rx_backpressure");
		end
		wait_jobs(done0 + 6);
		check_cond("receive FIFO not empty after six blocks were read", rx_empty);
		check_word("rx_backpressure mosi count", 32'(sent.size()), 32'(rec_cnt));
		for (int i = 0; i < sent.size(); i++) begin
			check_word($sformatf("rx_backpressure mosi word %0d", i), sent[i], rec_words[i]);
		end
		end_test("rx_backpressure");

		total_errors += test_errors;
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/api_cfg_pkg.sv
logic/api_link_pkg.sv
logic/api_timer.sv
logic/api_phy.sv
logic/api_fifo.sv
logic/api_ctrl.sv
logic/api_rx_tag.sv
logic/api_top.sv
testbench/api_chip_model.sv
testbench/api_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: run clean

run: obj_dir/Vapi_tb
	@out=$$(./obj_dir/Vapi_tb); echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

obj_dir/Vapi_tb: sim.f $(SRCS) logic/api_macros.svh
	verilator --binary --timing --assert -f sim.f --top-module api_tb -o Vapi_tb

clean:
	rm -rf obj_dir
